// File: rtl/cache_pkg.sv
package cache_pkg;

	// address and data geometry
	localparam int ADDR_LEN = 27;
	localparam int DATA_LEN = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_LEN = DATA_LEN * LINE_WORDS;

	// byte address split, msb to lsb
	localparam int TAG_LEN = 13;
	localparam int INDEX_LEN = 10;
	localparam int OFFSET_LEN = 2;
	localparam int BYTE_LEN = 2;

	// one line per index, direct mapped
	localparam int LINE_NUM = 1 << INDEX_LEN;

	typedef logic [ADDR_LEN-1:0] addr_t;
	typedef logic [DATA_LEN-1:0] word_t;
	// word 0 sits in bits 31:0
	typedef logic [LINE_LEN-1:0] line_t;
	typedef logic [TAG_LEN-1:0] tag_t;
	typedef logic [INDEX_LEN-1:0] index_t;
	typedef logic [OFFSET_LEN-1:0] offset_t;
	// tag and index, line aligned
	typedef logic [TAG_LEN+INDEX_LEN-1:0] line_addr_t;

	// cpu request, write data ignored on reads
	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// read word, valid with done
	typedef struct packed {
		word_t rdata;
	} cpu_rsp_t;

	// request after the address split
	typedef struct packed {
		logic write;
		tag_t tag;
		index_t index;
		offset_t offset;
		word_t wdata;
	} dec_req_t;

	// write = 1 is a write-back, write = 0 a fill
	typedef struct packed {
		logic write;
		line_addr_t line_addr;
		line_t data;
	} mem_req_t;

	typedef struct packed {
		line_t line;
	} mem_rsp_t;

endpackage

// File: rtl/line_ram.sv
`timescale 1ns/1ps

module line_ram #(
	parameter type payload_t = cache_pkg::line_t
) (
	input logic clk,
	input cache_pkg::index_t index,
	input logic we,
	input payload_t wdata,
	output payload_t rdata
);
	import cache_pkg::*;

	// one entry per cache line
	payload_t mem [LINE_NUM];

	// read before write
	// rdata shows the old entry the cycle after a write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end
		rdata <= mem[index];
	end

	// index comes from the decoder register
	// must be settled whenever a write lands
	a_index_known_on_write: assert property (
		@(posedge clk) we |-> !$isunknown(index)
	) else $error("line_ram write with unknown index");

endmodule

// File: rtl/cpu_req_decoder.sv
`timescale 1ns/1ps

module cpu_req_decoder (
	input logic clk,
	input logic rstn,
	input logic cpu_req_valid,
	input cache_pkg::cpu_req_t cpu_req,
	input logic cpu_done,
	output logic dec_valid,
	output cache_pkg::dec_req_t dec_req
);
	import cache_pkg::*;

	// high from strobe up to done
	logic busy;

	// strobe delayed by one cycle, busy tracking
	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec_valid <= 1'b0;
			busy <= 1'b0;
		end else begin
			dec_valid <= cpu_req_valid;
			if (cpu_req_valid) begin
				busy <= 1'b1;
			end else if (cpu_done) begin
				busy <= 1'b0;
			end
		end
	end

	// request fields held until the next strobe
	// byte bits of the address dropped here
	always_ff @(posedge clk) begin
		if (cpu_req_valid) begin
			dec_req.write <= cpu_req.write;
			dec_req.tag <= cpu_req.addr[ADDR_LEN-1 -: TAG_LEN];
			dec_req.index <= cpu_req.addr[BYTE_LEN+OFFSET_LEN +: INDEX_LEN];
			dec_req.offset <= cpu_req.addr[BYTE_LEN +: OFFSET_LEN];
			dec_req.wdata <= cpu_req.wdata;
		end
	end

	// only one request in flight
	a_no_strobe_while_busy: assert property (
		@(posedge clk) disable iff (!rstn) cpu_req_valid |-> !busy
	) else $error("cpu strobe while a request is still in flight");

	// done only ends a request that was started
	a_done_needs_request: assert property (
		@(posedge clk) disable iff (!rstn) cpu_done |-> busy
	) else $error("cpu_done without a pending request");

endmodule

// File: rtl/miss_fsm.sv
`timescale 1ns/1ps

module miss_fsm (
	input logic clk,
	input logic rstn,
	input logic dec_valid,
	input cache_pkg::dec_req_t dec_req,
	input cache_pkg::tag_t tag_rdata,
	input cache_pkg::line_t line_rdata,
	output logic tag_we,
	output logic line_we,
	output cache_pkg::line_t line_wdata,
	output logic issue_wb,
	output logic issue_fill,
	input logic fill_valid,
	input cache_pkg::line_t fill_line,
	output logic cpu_done,
	output cache_pkg::cpu_rsp_t cpu_rsp
);
	import cache_pkg::*;

	typedef enum logic [2:0] {
		idle,
		lookup,
		compare,
		write_back,
		fill_wait,
		refill
	} state_t;

	state_t state;
	state_t state_nxt;

	// per line status, cleared on reset
	logic [LINE_NUM-1:0] valid_q;
	logic [LINE_NUM-1:0] dirty_q;

	// lookup results, used one cycle later in compare
	logic hit_q;
	word_t word_q;

	logic tag_match;
	logic victim_dirty;
	logic hit_wr;
	logic fill_wr;
	line_t merge_src;

	// word slice of a line
	function automatic word_t get_word(line_t line, offset_t offset);
		return line[offset*DATA_LEN +: DATA_LEN];
	endfunction

	// replace one word, keep the other three
	function automatic line_t merge_word(line_t line, offset_t offset, word_t word);
		line_t merged;
		merged = line;
		merged[offset*DATA_LEN +: DATA_LEN] = word;
		return merged;
	endfunction

	// rdata is valid from lookup on
	// index stays put until the next request
	assign tag_match = valid_q[dec_req.index] && (tag_rdata == dec_req.tag);
	assign victim_dirty = valid_q[dec_req.index] && dirty_q[dec_req.index];

	// write hit merges into the current line
	assign hit_wr = (state == compare) && hit_q && dec_req.write;
	// fill lands straight from the memory port
	assign fill_wr = (state == fill_wait) && fill_valid;

	assign tag_we = fill_wr;
	assign line_we = hit_wr || fill_wr;

	// fill line or cached line as merge base
	assign merge_src = (state == fill_wait) ? fill_line : line_rdata;
	assign line_wdata = dec_req.write ?
		merge_word(merge_src, dec_req.offset, dec_req.wdata) : merge_src;

	// victim leaves first, then the fill
	assign issue_wb = (state == compare) && !hit_q && victim_dirty;
	assign issue_fill = ((state == compare) && !hit_q && !victim_dirty) ||
		(state == write_back);

	// hit path ends the request
	assign cpu_done = (state == compare) && hit_q;
	assign cpu_rsp.rdata = word_q;

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (dec_valid) begin
					state_nxt = lookup;
				end
			end
			lookup: begin
				state_nxt = compare;
			end
			compare: begin
				if (hit_q) begin
					state_nxt = idle;
				end else if (victim_dirty) begin
					state_nxt = write_back;
				end else begin
					state_nxt = fill_wait;
				end
			end
			write_back: begin
				state_nxt = fill_wait;
			end
			fill_wait: begin
				if (fill_valid) begin
					state_nxt = refill;
				end
			end
			// ram re-reads the new line here
			refill: begin
				state_nxt = lookup;
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	// registered compare, word picked in the same step
	always_ff @(posedge clk) begin
		if (state == lookup) begin
			hit_q <= tag_match;
			word_q <= get_word(line_rdata, dec_req.offset);
		end
	end

	// fill makes the line valid
	// dirty only if the miss was a write
	always_ff @(posedge clk) begin
		if (!rstn) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (fill_wr) begin
				valid_q[dec_req.index] <= 1'b1;
				dirty_q[dec_req.index] <= dec_req.write;
			end
			if (hit_wr) begin
				dirty_q[dec_req.index] <= 1'b1;
			end
		end
	end

	// write-back only while the arrays still hold a line of another tag
	a_wb_on_conflict: assert property (
		@(posedge clk) disable iff (!rstn) issue_wb |-> !tag_match
	) else $error("write-back while the request tag still matches");

	// memory port must not deliver a line we did not wait for
	a_fill_only_when_waiting: assert property (
		@(posedge clk) disable iff (!rstn) fill_valid |-> state == fill_wait
	) else $error("fill_valid outside fill_wait");

endmodule

// File: rtl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
	input logic clk,
	input logic rstn,
	input logic issue_wb,
	input logic issue_fill,
	input cache_pkg::dec_req_t dec_req,
	input cache_pkg::tag_t victim_tag,
	input cache_pkg::line_t victim_line,
	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_rsp_valid,
	input cache_pkg::mem_rsp_t mem_rsp,
	output logic fill_valid,
	output cache_pkg::line_t fill_line
);
	import cache_pkg::*;

	line_addr_t wb_addr;
	line_addr_t fill_addr;
	// set by the fill request, cleared by its response
	logic fill_pending;

	// old tag for the victim, request tag for the fill
	assign wb_addr = {victim_tag, dec_req.index};
	assign fill_addr = {dec_req.tag, dec_req.index};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			mem_req_valid <= 1'b0;
			fill_pending <= 1'b0;
		end else begin
			mem_req_valid <= issue_wb || issue_fill;
			if (issue_fill) begin
				fill_pending <= 1'b1;
			end else if (mem_rsp_valid) begin
				fill_pending <= 1'b0;
			end
		end
	end

	// request payload, data zero on fills
	always_ff @(posedge clk) begin
		if (issue_wb) begin
			mem_req.write <= 1'b1;
			mem_req.line_addr <= wb_addr;
			mem_req.data <= victim_line;
		end else if (issue_fill) begin
			mem_req.write <= 1'b0;
			mem_req.line_addr <= fill_addr;
			mem_req.data <= '0;
		end
	end

	// response goes straight through
	assign fill_valid = mem_rsp_valid;
	assign fill_line = mem_rsp.line;

	a_rsp_needs_fill: assert property (
		@(posedge clk) disable iff (!rstn) mem_rsp_valid |-> fill_pending
	) else $error("memory response with no fill outstanding");

	a_one_fill_at_a_time: assert property (
		@(posedge clk) disable iff (!rstn) issue_fill |-> !fill_pending
	) else $error("second fill issued while one is outstanding");

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
	input logic clk,
	input logic rstn,
	input logic cpu_req_valid,
	input cache_pkg::cpu_req_t cpu_req,
	output logic cpu_done,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_rsp_valid,
	input cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	logic dec_valid;
	dec_req_t dec_req;

	// array side
	tag_t tag_rdata;
	line_t line_rdata;
	logic tag_we;
	logic line_we;
	line_t line_wdata;

	// controller to memory port
	logic issue_wb;
	logic issue_fill;
	logic fill_valid;
	line_t fill_line;

	cpu_req_decoder cpu_req_decoder_i (
		.clk(clk),
		.rstn(rstn),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req(cpu_req),
		.cpu_done(cpu_done),
		.dec_valid(dec_valid),
		.dec_req(dec_req)
	);

	// tags written only on a fill, with the request tag
	line_ram #(.payload_t(tag_t)) tag_ram_i (
		.clk(clk),
		.index(dec_req.index),
		.we(tag_we),
		.wdata(dec_req.tag),
		.rdata(tag_rdata)
	);

	line_ram #(.payload_t(line_t)) data_ram_i (
		.clk(clk),
		.index(dec_req.index),
		.we(line_we),
		.wdata(line_wdata),
		.rdata(line_rdata)
	);

	miss_fsm miss_fsm_i (
		.clk(clk),
		.rstn(rstn),
		.dec_valid(dec_valid),
		.dec_req(dec_req),
		.tag_rdata(tag_rdata),
		.line_rdata(line_rdata),
		.tag_we(tag_we),
		.line_we(line_we),
		.line_wdata(line_wdata),
		.issue_wb(issue_wb),
		.issue_fill(issue_fill),
		.fill_valid(fill_valid),
		.fill_line(fill_line),
		.cpu_done(cpu_done),
		.cpu_rsp(cpu_rsp)
	);

	// victim is whatever the arrays show during compare
	mem_port mem_port_i (
		.clk(clk),
		.rstn(rstn),
		.issue_wb(issue_wb),
		.issue_fill(issue_fill),
		.dec_req(dec_req),
		.victim_tag(tag_rdata),
		.victim_line(line_rdata),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp),
		.fill_valid(fill_valid),
		.fill_line(fill_line)
	);

endmodule

// File: sim/main_memory_model.sv
`timescale 1ns/1ps

module main_memory_model (
	input logic clk,
	input logic mem_req_valid,
	input cache_pkg::mem_req_t mem_req,
	output logic mem_rsp_valid,
	output cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	localparam int FILL_LATENCY = 6;
	localparam int LOG_DEPTH = 1024;

	// only lines that came back as write-backs are stored
	line_t store [line_addr_t];
	// every request in arrival order
	mem_req_t req_log [LOG_DEPTH];
	int req_count = 0;

	line_addr_t fill_addr;
	// cycles left until the fill answer
	int wait_cnt;

	// untouched words hold their word address xor 5a5a0000
	function automatic line_t read_line(line_addr_t line_addr);
		line_t line;
		if (store.exists(line_addr)) begin
			return store[line_addr];
		end
		for (int w = 0; w < LINE_WORDS; w++) begin
			line[w*DATA_LEN +: DATA_LEN] = {7'd0, line_addr, w[1:0]} ^ 32'h5a5a0000;
		end
		return line;
	endfunction

	initial begin
		mem_rsp_valid = 1'b0;
		mem_rsp = '0;
		fill_addr = '0;
		wait_cnt = 0;
		forever begin
			// response side, driven just after the edge
			@(posedge clk);
			#1;
			mem_rsp_valid = 1'b0;
			if (wait_cnt == 1) begin
				mem_rsp_valid = 1'b1;
				mem_rsp.line = read_line(fill_addr);
			end
			if (wait_cnt > 0) begin
				wait_cnt--;
			end
			// request side, sampled mid cycle
			@(negedge clk);
			if (mem_req_valid) begin
				if (req_count < LOG_DEPTH) begin
					req_log[req_count] = mem_req;
				end
				req_count++;
				if (mem_req.write) begin
					store[mem_req.line_addr] = mem_req.data;
				end else begin
					fill_addr = mem_req.line_addr;
					wait_cnt = FILL_LATENCY;
				end
			end
		end
	end

endmodule

// File: sim/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;
	import cache_pkg::*;

	// worst miss with write-back is well under 20 cycles
	localparam int NUM_OPS = 310;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 200;

	logic clk;
	logic rstn;
	logic cpu_req_valid;
	cpu_req_t cpu_req;
	logic cpu_done;
	cpu_rsp_t cpu_rsp;
	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_rsp_valid;
	mem_rsp_t mem_rsp;

	integer seed = 96;
	int cyc = 0;
	int n_errors = 0;
	int n_checks = 0;
	int n_tests = 0;
	int test_errs;
	string test_name;

	// request in flight, set by stimulus, cleared on done
	logic in_flight = 1'b0;
	logic exp_read;
	cpu_rsp_t exp_rsp;
	int strobe_cyc;
	int last_latency;
	int done_count = 0;

	// words written so far, keyed by word address
	word_t shadow [logic [24:0]];
	tag_t rand_tags [4] = '{13'h040, 13'h041, 13'h1ff, 13'h0a5};

	// line each index should hold in the random test
	logic [LINE_NUM-1:0] res_valid = '0;
	logic [LINE_NUM-1:0] res_dirty = '0;
	tag_t res_tag [LINE_NUM];

	cache_top cache_top_i (
		.clk(clk),
		.rstn(rstn),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req(cpu_req),
		.cpu_done(cpu_done),
		.cpu_rsp(cpu_rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp)
	);

	main_memory_model mem_model_i (
		.clk(clk),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a request never completed", cyc);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic addr_t make_addr(tag_t tag, index_t index, offset_t offset);
		return {tag, index, offset, 2'b00};
	endfunction

	// last written word, else the memory's initial rule
	function automatic word_t expected_word(addr_t addr);
		logic [24:0] waddr;
		waddr = addr[ADDR_LEN-1:BYTE_LEN];
		if (shadow.exists(waddr)) begin
			return shadow[waddr];
		end
		return {7'd0, waddr} ^ 32'h5a5a0000;
	endfunction

	function automatic line_t expected_line(line_addr_t line_addr);
		line_t line;
		for (int w = 0; w < LINE_WORDS; w++) begin
			line[w*DATA_LEN +: DATA_LEN] = expected_word({line_addr, w[1:0], 2'b00});
		end
		return line;
	endfunction

	task automatic check_word(string name, cpu_rsp_t got, cpu_rsp_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got.rdata, exp.rdata);
			n_errors++;
		end
	endtask

	task automatic check_mem_req(string name, mem_req_t got, mem_req_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %s got write %h addr %h data %h", name,
				got.write, got.line_addr, got.data);
			$display("ERR %s expected write %h addr %h data %h", name,
				exp.write, exp.line_addr, exp.data);
			n_errors++;
		end
	endtask

	task automatic check_latency(string name, int got, int exp);
		n_checks++;
		if (got != exp) begin
			$display("ERR %s got %h expected %h cycles", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		n_checks++;
		if (got != exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic begin_test(string name);
		n_tests++;
		test_name = name;
		test_errs = n_errors;
	endtask

	task automatic end_test();
		$display("test %0d %s: %0d errors", n_tests, test_name, n_errors - test_errs);
	endtask

	// one strobe, then wait for the done seen by the monitor
	task automatic run_op(logic write, addr_t addr, word_t wdata);
		int done_before;
		@(posedge clk);
		#1;
		exp_read = !write;
		exp_rsp.rdata = expected_word(addr);
		if (write) begin
			shadow[addr[ADDR_LEN-1:BYTE_LEN]] = wdata;
		end
		done_before = done_count;
		strobe_cyc = cyc;
		in_flight = 1'b1;
		cpu_req.write = write;
		cpu_req.addr = addr;
		cpu_req.wdata = wdata;
		cpu_req_valid = 1'b1;
		@(posedge clk);
		#1;
		cpu_req_valid = 1'b0;
		while (done_count == done_before) begin
			@(posedge clk);
		end
	endtask

	// read data compared mid cycle while done is high
	always @(negedge clk) begin
		if (rstn && cpu_done) begin
			if (!in_flight) begin
				$display("cpu_done pulsed with no request in flight");
				n_errors++;
			end else begin
				last_latency = cyc - strobe_cyc;
				if (exp_read) begin
					check_word("cpu_rsp", cpu_rsp, exp_rsp);
				end
				in_flight = 1'b0;
				done_count++;
			end
		end
	end

	initial begin
		int base;
		int n_done;
		int n_mem;
		logic [31:0] r;
		addr_t a_addr;
		addr_t b_addr;
		mem_req_t exp_req;
		mem_req_t wb_req;
		index_t r_index;
		tag_t r_tag;
		logic r_hit;
		logic r_wb;
		clk = 1'b0;
		rstn = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		n_done = 0;
		n_mem = 0;
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;

		begin_test("idle after reset");
		repeat (10) begin
			@(negedge clk);
			n_done += int'(cpu_done);
			n_mem += int'(mem_req_valid);
		end
		check_count("cpu_done pulses", n_done, 0);
		check_count("mem_req_valid pulses", n_mem, 0);
		end_test();

		// fill address is tag and index, no write-back
		begin_test("cold read");
		a_addr = make_addr(13'h012, 10'h100, 2'd3);
		base = mem_model_i.req_count;
		run_op(1'b0, a_addr, '0);
		check_count("mem requests", mem_model_i.req_count - base, 1);
		exp_req.write = 1'b0;
		exp_req.line_addr = a_addr[ADDR_LEN-1:OFFSET_LEN+BYTE_LEN];
		exp_req.data = '0;
		check_mem_req("mem_req", mem_model_i.req_log[base], exp_req);
		end_test();

		begin_test("read hit");
		base = mem_model_i.req_count;
		run_op(1'b0, make_addr(13'h012, 10'h100, 2'd0), '0);
		check_count("mem requests", mem_model_i.req_count - base, 0);
		check_latency("cpu_done latency", last_latency, 3);
		end_test();

		// write miss allocates, second word is a hit
		begin_test("write miss then hits");
		a_addr = make_addr(13'h0a5, 10'h033, 2'd1);
		base = mem_model_i.req_count;
		run_op(1'b1, a_addr, 32'hcafe0001);
		check_count("mem requests", mem_model_i.req_count - base, 1);
		run_op(1'b0, a_addr, '0);
		base = mem_model_i.req_count;
		run_op(1'b1, make_addr(13'h0a5, 10'h033, 2'd2), 32'hbeef0002);
		check_count("mem requests", mem_model_i.req_count - base, 0);
		check_latency("cpu_done latency", last_latency, 3);
		end_test();

		// same index, new tag evicts the dirty line
		begin_test("dirty eviction");
		b_addr = make_addr(13'h1c3, 10'h033, 2'd1);
		exp_req.write = 1'b1;
		exp_req.line_addr = a_addr[ADDR_LEN-1:OFFSET_LEN+BYTE_LEN];
		exp_req.data = expected_line(exp_req.line_addr);
		base = mem_model_i.req_count;
		run_op(1'b0, b_addr, '0);
		check_count("mem requests", mem_model_i.req_count - base, 2);
		check_mem_req("write-back", mem_model_i.req_log[base], exp_req);
		exp_req.write = 1'b0;
		exp_req.line_addr = b_addr[ADDR_LEN-1:OFFSET_LEN+BYTE_LEN];
		exp_req.data = '0;
		check_mem_req("fill", mem_model_i.req_log[base+1], exp_req);
		run_op(1'b0, a_addr, '0);
		end_test();

		// few tags over 8 indices, lots of conflicts
		begin_test("random traffic");
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			r_tag = rand_tags[r[1:0]];
			r_index = 10'h200 + {7'd0, r[4:2]};
			b_addr = make_addr(r_tag, r_index, r[6:5]);
			// direct mapped, so the resident line decides hit and victim
			r_hit = res_valid[r_index] && (res_tag[r_index] == r_tag);
			r_wb = !r_hit && res_valid[r_index] && res_dirty[r_index];
			if (r_wb) begin
				wb_req.write = 1'b1;
				wb_req.line_addr = {res_tag[r_index], r_index};
				wb_req.data = expected_line(wb_req.line_addr);
			end
			exp_req.write = 1'b0;
			exp_req.line_addr = {r_tag, r_index};
			exp_req.data = '0;
			base = mem_model_i.req_count;
			run_op(r[7], b_addr, $random(seed));
			if (r_hit) begin
				check_count("mem requests", mem_model_i.req_count - base, 0);
			end else if (r_wb) begin
				check_count("mem requests", mem_model_i.req_count - base, 2);
				check_mem_req("write-back", mem_model_i.req_log[base], wb_req);
				check_mem_req("fill", mem_model_i.req_log[base+1], exp_req);
			end else begin
				check_count("mem requests", mem_model_i.req_count - base, 1);
				check_mem_req("fill", mem_model_i.req_log[base], exp_req);
			end
			res_dirty[r_index] = (r_hit && res_dirty[r_index]) || r[7];
			res_valid[r_index] = 1'b1;
			res_tag[r_index] = r_tag;
		end
		end_test();

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: vlog.f
rtl/cache_pkg.sv
rtl/line_ram.sv
rtl/cpu_req_decoder.sv
rtl/miss_fsm.sv
rtl/mem_port.sv
rtl/cache_top.sv
sim/main_memory_model.sv
sim/tb_cache_top.sv

// File: Makefile
SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: run clean

obj_dir/Vtb_cache_top: vlog.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module tb_cache_top -f vlog.f -Mdir obj_dir -o Vtb_cache_top

run: obj_dir/Vtb_cache_top
	./obj_dir/Vtb_cache_top > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
